// File: include/mini_vec_defs.svh
/*
  Shape and width constants for the mini_vec vector coprocessor.
  Included by the package and by every RTL file that sizes storage or loops.
*/
`ifndef MINI_VEC_DEFS_SVH
`define MINI_VEC_DEFS_SVH

// Register file shape
`define MV_NR_VREGS 8
`define MV_NR_ELEMS 4
`define MV_ELEM_W   32

// Memory byte address
`define MV_ADDR_W   32

// Instruction tag carried through to the result channel
`define MV_ID_W     4

`endif

// File: verilog/mini_vec_pkg.sv
/*
  Types shared by the mini_vec controller, register file and execution units.
  Opcode encoding, instruction and dispatch structs, VRF write and memory bus.
*/
`include "mini_vec_defs.svh"

package mini_vec_pkg;

  typedef enum logic [3:0] {
    OP_VADD,
    OP_VSUB,
    OP_VAND,
    OP_VOR,
    OP_VXOR,
    OP_VLE,
    OP_VSE,
    OP_VSLIDEUP,
    OP_VSLIDEDOWN
  } vec_op_e;

  typedef logic [$clog2(`MV_NR_VREGS)-1:0] vreg_idx_t;

  // Element 0 sits in the low bits
  typedef logic [`MV_NR_ELEMS-1:0][`MV_ELEM_W-1:0] vec_data_t;

  typedef struct packed {
    vec_op_e               op;
    vreg_idx_t             vd;
    vreg_idx_t             vs1;
    vreg_idx_t             vs2;
    logic [`MV_ADDR_W-1:0] addr;
    logic [`MV_ID_W-1:0]   id;
  } vec_instr_t;

  // Dispatch bus from the controller to the units
  typedef struct packed {
    vec_op_e               op;
    vreg_idx_t             vd;
    vreg_idx_t             vs1;
    vreg_idx_t             vs2;
    logic [`MV_ADDR_W-1:0] addr;
    logic [`MV_ID_W-1:0]   id;
  } unit_req_t;

  typedef struct packed {
    logic [`MV_ID_W-1:0] id;
  } unit_rsp_t;

  typedef struct packed {
    vreg_idx_t idx;
    vec_data_t data;
  } vrf_wr_t;

  typedef struct packed {
    logic [`MV_ADDR_W-1:0] addr;
    logic [`MV_ELEM_W-1:0] wdata;
    logic                  write;
  } mem_req_t;

  typedef struct packed {
    logic [`MV_ELEM_W-1:0] rdata;
  } mem_resp_t;

endpackage

// File: verilog/mini_vec_vrf.sv
/*
  Vector register file with four combinational read ports and three write ports.
  Write port order gives priority, the highest index wins on a collision.
*/
`timescale 1ns/100ps
`include "mini_vec_defs.svh"

module mini_vec_vrf (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  mini_vec_pkg::vreg_idx_t [3:0]     raddr_i,
  output mini_vec_pkg::vec_data_t [3:0]     rdata_o,
  input  logic                    [2:0]     we_i,
  input  mini_vec_pkg::vrf_wr_t   [2:0]     wr_i
);
  import mini_vec_pkg::*;

  vec_data_t regs_q [`MV_NR_VREGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < `MV_NR_VREGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // Later ports overwrite earlier ones
      for (int p = 0; p < 3; p++) begin
        if (we_i[p]) begin
          regs_q[wr_i[p].idx] <= wr_i[p].data;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rdata_o[p] = regs_q[raddr_i[p]];
    end
  end

endmodule

// File: verilog/mini_vec_controller.sv
/*
  Issue control for mini_vec. Decodes each instruction to a unit, tracks
  pending destination registers in a scoreboard, dispatches on the shared
  bus and funnels unit completions into one held result register.
  Unit index 0 is the VFU, 1 the VLSU and 2 the VSLDU.
*/
`timescale 1ns/100ps
`include "mini_vec_defs.svh"

module mini_vec_controller (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Issue
  input  logic                            issue_valid_i,
  output logic                            issue_ready_o,
  input  mini_vec_pkg::vec_instr_t        issue_req_i,
  // Result
  output logic                            result_valid_o,
  input  logic                            result_ready_i,
  output mini_vec_pkg::unit_rsp_t         result_o,
  // Dispatch
  output mini_vec_pkg::unit_req_t         unit_req_o,
  output logic                      [2:0] unit_valid_o,
  input  logic                      [2:0] unit_ready_i,
  // Unit completions
  input  logic                      [2:0] rsp_valid_i,
  input  mini_vec_pkg::unit_rsp_t   [2:0] rsp_i,
  output logic                      [2:0] rsp_ready_o,
  // VRF writes, for scoreboard release
  input  logic                      [2:0] vrf_we_i,
  input  mini_vec_pkg::vrf_wr_t     [2:0] vrf_wr_i
);
  import mini_vec_pkg::*;

  logic [2:0]              unit_sel;
  logic                    writes_vd;
  logic                    hazard;
  logic                    issue_fire;
  logic [`MV_NR_VREGS-1:0] busy_q, busy_d;
  logic [2:0]              grant;
  logic                    result_valid_q;
  unit_rsp_t               result_q;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    unit_sel  = 3'b000;
    writes_vd = 1'b1;
    case (issue_req_i.op)
      OP_VADD, OP_VSUB, OP_VAND, OP_VOR, OP_VXOR: unit_sel = 3'b001;
      OP_VLE:                                    unit_sel = 3'b010;
      OP_VSE: begin
        unit_sel  = 3'b010;
        writes_vd = 1'b0;
      end
      OP_VSLIDEUP, OP_VSLIDEDOWN:                unit_sel = 3'b100;
      // Unknown opcodes never find a ready unit
      default:                                   unit_sel = 3'b000;
    endcase
  end

  ////////////////////
  // Scoreboard
  ////////////////////

  assign hazard = busy_q[issue_req_i.vs1] | busy_q[issue_req_i.vs2] | busy_q[issue_req_i.vd];

  assign issue_ready_o = !hazard && |(unit_sel & unit_ready_i);
  assign issue_fire    = issue_valid_i && issue_ready_o;

  // Broadcast bus, each unit sees only its own strobe
  assign unit_req_o   = unit_req_t'(issue_req_i);
  assign unit_valid_o = unit_sel & {3{issue_valid_i && !hazard}};

  always_comb begin
    busy_d = busy_q;
    for (int k = 0; k < 3; k++) begin
      if (vrf_we_i[k]) begin
        busy_d[vrf_wr_i[k].idx] = 1'b0;
      end
    end
    if (issue_fire && writes_vd) begin
      busy_d[issue_req_i.vd] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  ////////////////////
  // Completion
  ////////////////////

  // Fixed priority VFU, VLSU, VSLDU when the result slot frees up
  always_comb begin
    grant = 3'b000;
    if (!result_valid_q || result_ready_i) begin
      if (rsp_valid_i[0]) begin
        grant = 3'b001;
      end else if (rsp_valid_i[1]) begin
        grant = 3'b010;
      end else if (rsp_valid_i[2]) begin
        grant = 3'b100;
      end
    end
  end

  assign rsp_ready_o = grant;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_q <= 1'b0;
    end else if (|grant) begin
      result_valid_q <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < 3; k++) begin
      if (grant[k]) begin
        result_q <= rsp_i[k];
      end
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

// File: verilog/mini_vec_vfu.sv
/*
  Element-wise integer arithmetic unit. Stage 1 captures operands, stage 2
  holds the result, writes it back once and offers the completion.
*/
`timescale 1ns/100ps
`include "mini_vec_defs.svh"

module mini_vec_vfu (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mini_vec_pkg::unit_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mini_vec_pkg::vec_data_t vs1_data_i,
  input  mini_vec_pkg::vec_data_t vs2_data_i,
  output logic                    rsp_valid_o,
  output mini_vec_pkg::unit_rsp_t rsp_o,
  input  logic                    rsp_ready_i,
  output logic                    vrf_we_o,
  output mini_vec_pkg::vrf_wr_t   vrf_wr_o
);
  import mini_vec_pkg::*;

  logic                s1_valid_q, s2_valid_q, s2_we_q;
  logic                advance;
  vec_op_e             s1_op_q;
  vreg_idx_t           s1_vd_q, s2_vd_q;
  logic [`MV_ID_W-1:0] s1_id_q, s2_id_q;
  vec_data_t           s1_a_q, s1_b_q, s2_res_q, res_d;

  // Subtract follows the RVV order, vs2 minus vs1
  function automatic logic [`MV_ELEM_W-1:0] alu_elem(
    input vec_op_e               op,
    input logic [`MV_ELEM_W-1:0] a,
    input logic [`MV_ELEM_W-1:0] b
  );
    case (op)
      OP_VADD: return b + a;
      OP_VSUB: return b - a;
      OP_VAND: return b & a;
      OP_VOR:  return b | a;
      OP_VXOR: return b ^ a;
      default: return '0;
    endcase
  endfunction

  // Whole pipe freezes while stage 2 waits on the controller
  assign advance     = !s2_valid_q || rsp_ready_i;
  assign req_ready_o = advance;

  always_comb begin
    for (int e = 0; e < `MV_NR_ELEMS; e++) begin
      res_d[e] = alu_elem(s1_op_q, s1_a_q[e], s1_b_q[e]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      s2_we_q    <= 1'b0;
    end else begin
      // Write strobe lasts only the cycle stage 2 is loaded
      s2_we_q <= advance && s1_valid_q;
      if (advance) begin
        s1_valid_q <= req_valid_i;
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance && req_valid_i) begin
      s1_op_q <= req_i.op;
      s1_vd_q <= req_i.vd;
      s1_id_q <= req_i.id;
      s1_a_q  <= vs1_data_i;
      s1_b_q  <= vs2_data_i;
    end
    if (advance && s1_valid_q) begin
      s2_vd_q  <= s1_vd_q;
      s2_id_q  <= s1_id_q;
      s2_res_q <= res_d;
    end
  end

  assign rsp_valid_o   = s2_valid_q;
  assign rsp_o.id      = s2_id_q;
  assign vrf_we_o      = s2_we_q;
  assign vrf_wr_o.idx  = s2_vd_q;
  assign vrf_wr_o.data = s2_res_q;

endmodule

// File: verilog/mini_vec_vlsu.sv
/*
  Unit-stride load/store sequencer. Issues one word request per element at
  base, base+4, and so on, collects load data in order and writes the whole
  vector back once. Handles a single instruction at a time.
*/
`timescale 1ns/100ps
`include "mini_vec_defs.svh"

module mini_vec_vlsu (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mini_vec_pkg::unit_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mini_vec_pkg::vec_data_t store_data_i,
  output logic                    rsp_valid_o,
  output mini_vec_pkg::unit_rsp_t rsp_o,
  input  logic                    rsp_ready_i,
  output logic                    vrf_we_o,
  output mini_vec_pkg::vrf_wr_t   vrf_wr_o,
  output logic                    mem_req_valid_o,
  output mini_vec_pkg::mem_req_t  mem_req_o,
  input  logic                    mem_req_ready_i,
  input  logic                    mem_resp_valid_i,
  input  mini_vec_pkg::mem_resp_t mem_resp_i
);
  import mini_vec_pkg::*;

  localparam int unsigned IDX_W = $clog2(`MV_NR_ELEMS);
  localparam int unsigned CNT_W = IDX_W + 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`MV_NR_ELEMS - 1);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_FINISH} state_e;

  state_e                state_q;
  logic [CNT_W-1:0]      req_cnt_q, rsp_cnt_q;
  logic                  we_q;
  logic                  store_q;
  logic                  req_fire;
  vreg_idx_t             vd_q;
  logic [`MV_ID_W-1:0]   id_q;
  logic [`MV_ADDR_W-1:0] base_q;
  vec_data_t             buf_q;

  assign req_ready_o     = (state_q == ST_IDLE);
  assign mem_req_valid_o = (state_q == ST_REQ) && (req_cnt_q <= LAST);
  assign req_fire        = mem_req_valid_o && mem_req_ready_i;

  // Byte address of the current element
  assign mem_req_o.addr  = base_q + `MV_ADDR_W'({req_cnt_q, 2'b00});
  assign mem_req_o.wdata = buf_q[req_cnt_q[IDX_W-1:0]];
  assign mem_req_o.write = store_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
      we_q      <= 1'b0;
    end else begin
      we_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_valid_i) begin
            state_q   <= ST_REQ;
            req_cnt_q <= '0;
            rsp_cnt_q <= '0;
          end
        end
        ST_REQ: begin
          if (req_fire) begin
            req_cnt_q <= req_cnt_q + 1'b1;
          end
          if (store_q) begin
            // Stores end on the last accepted request
            if (req_fire && req_cnt_q == LAST) begin
              state_q <= ST_FINISH;
            end
          end else if (mem_resp_valid_i) begin
            rsp_cnt_q <= rsp_cnt_q + 1'b1;
            if (rsp_cnt_q == LAST) begin
              state_q <= ST_FINISH;
              we_q    <= 1'b1;
            end
          end
        end
        ST_FINISH: begin
          if (rsp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_valid_i) begin
      store_q <= (req_i.op == OP_VSE);
      vd_q    <= req_i.vd;
      id_q    <= req_i.id;
      base_q  <= req_i.addr;
      buf_q   <= store_data_i;
    end else if (state_q == ST_REQ && !store_q && mem_resp_valid_i) begin
      buf_q[rsp_cnt_q[IDX_W-1:0]] <= mem_resp_i.rdata;
    end
  end

  assign rsp_valid_o   = (state_q == ST_FINISH);
  assign rsp_o.id      = id_q;
  assign vrf_we_o      = we_q;
  assign vrf_wr_o.idx  = vd_q;
  assign vrf_wr_o.data = buf_q;

endmodule

// File: verilog/mini_vec_vsldu.sv
/*
  Slide unit. Moves every element one place up or down with zero fill and
  writes the result one cycle after acceptance.
*/
`timescale 1ns/100ps
`include "mini_vec_defs.svh"

module mini_vec_vsldu (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mini_vec_pkg::unit_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mini_vec_pkg::vec_data_t vs2_data_i,
  output logic                    rsp_valid_o,
  output mini_vec_pkg::unit_rsp_t rsp_o,
  input  logic                    rsp_ready_i,
  output logic                    vrf_we_o,
  output mini_vec_pkg::vrf_wr_t   vrf_wr_o
);
  import mini_vec_pkg::*;

  logic                valid_q, we_q;
  logic                accept;
  vreg_idx_t           vd_q;
  logic [`MV_ID_W-1:0] id_q;
  vec_data_t           res_q, slid;

  assign req_ready_o = !valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  // Vacated element stays zero
  always_comb begin
    slid = '0;
    for (int e = 1; e < `MV_NR_ELEMS; e++) begin
      if (req_i.op == OP_VSLIDEUP) begin
        slid[e] = vs2_data_i[e-1];
      end else begin
        slid[e-1] = vs2_data_i[e];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      we_q <= accept;
      if (accept) begin
        valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q  <= req_i.vd;
      id_q  <= req_i.id;
      res_q <= slid;
    end
  end

  assign rsp_valid_o   = valid_q;
  assign rsp_o.id      = id_q;
  assign vrf_we_o      = we_q;
  assign vrf_wr_o.idx  = vd_q;
  assign vrf_wr_o.data = res_q;

endmodule

// File: verilog/mini_vec.sv
/*
  Top level of the mini_vec vector coprocessor. Connects the controller,
  the register file and the arithmetic, load/store and slide units.
*/
`timescale 1ns/100ps

module mini_vec (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Issue
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  mini_vec_pkg::vec_instr_t issue_req_i,
  // Result
  output logic                     result_valid_o,
  input  logic                     result_ready_i,
  output mini_vec_pkg::unit_rsp_t  result_o,
  // Memory
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output mini_vec_pkg::mem_req_t   mem_req_o,
  input  logic                     mem_resp_valid_i,
  input  mini_vec_pkg::mem_resp_t  mem_resp_i
);
  import mini_vec_pkg::*;

  unit_req_t       unit_req;
  logic      [2:0] unit_valid, unit_ready;
  logic      [2:0] rsp_valid, rsp_ready;
  unit_rsp_t [2:0] rsp;
  logic      [2:0] vrf_we;
  vrf_wr_t   [2:0] vrf_wr;
  vreg_idx_t [3:0] vrf_raddr;
  vec_data_t [3:0] vrf_rdata;

  // Read ports: VFU vs1, VFU vs2, VLSU store source, VSLDU vs2
  assign vrf_raddr = {unit_req.vs2, unit_req.vd, unit_req.vs2, unit_req.vs1};

  mini_vec_controller i_controller (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_req_i   (issue_req_i),
    .result_valid_o(result_valid_o),
    .result_ready_i(result_ready_i),
    .result_o      (result_o),
    .unit_req_o    (unit_req),
    .unit_valid_o  (unit_valid),
    .unit_ready_i  (unit_ready),
    .rsp_valid_i   (rsp_valid),
    .rsp_i         (rsp),
    .rsp_ready_o   (rsp_ready),
    .vrf_we_i      (vrf_we),
    .vrf_wr_i      (vrf_wr)
  );

  mini_vec_vrf i_vrf (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .raddr_i(vrf_raddr),
    .rdata_o(vrf_rdata),
    .we_i   (vrf_we),
    .wr_i   (vrf_wr)
  );

  mini_vec_vfu i_vfu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (unit_req),
    .req_valid_i(unit_valid[0]),
    .req_ready_o(unit_ready[0]),
    .vs1_data_i (vrf_rdata[0]),
    .vs2_data_i (vrf_rdata[1]),
    .rsp_valid_o(rsp_valid[0]),
    .rsp_o      (rsp[0]),
    .rsp_ready_i(rsp_ready[0]),
    .vrf_we_o   (vrf_we[0]),
    .vrf_wr_o   (vrf_wr[0])
  );

  mini_vec_vlsu i_vlsu (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (unit_req),
    .req_valid_i     (unit_valid[1]),
    .req_ready_o     (unit_ready[1]),
    .store_data_i    (vrf_rdata[2]),
    .rsp_valid_o     (rsp_valid[1]),
    .rsp_o           (rsp[1]),
    .rsp_ready_i     (rsp_ready[1]),
    .vrf_we_o        (vrf_we[1]),
    .vrf_wr_o        (vrf_wr[1]),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_valid_i(mem_resp_valid_i),
    .mem_resp_i      (mem_resp_i)
  );

  mini_vec_vsldu i_vsldu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (unit_req),
    .req_valid_i(unit_valid[2]),
    .req_ready_o(unit_ready[2]),
    .vs2_data_i (vrf_rdata[3]),
    .rsp_valid_o(rsp_valid[2]),
    .rsp_o      (rsp[2]),
    .rsp_ready_i(rsp_ready[2]),
    .vrf_we_o   (vrf_we[2]),
    .vrf_wr_o   (vrf_wr[2])
  );

endmodule

// File: tests/mini_vec_tb.sv
/*
  Directed testbench for the mini_vec vector coprocessor.
  Holds a word memory with random stalls and delays, a sequential model of
  the registers and memory, and a result collector that tracks every id.
  Each test issues instructions, waits for completion and checks memory.
*/
`timescale 1ns/100ps
`include "mini_vec_defs.svh"

module mini_vec_tb;
  import mini_vec_pkg::*;

  localparam int NUM_INSTR       = 31;
  localparam int WATCHDOG_CYCLES = 200 * NUM_INSTR + 2000;
  localparam int WAIT_LIMIT      = 2000;

  logic       clk;
  logic       rst;
  logic       issue_valid;
  logic       issue_ready;
  vec_instr_t issue_req;
  logic       result_valid;
  logic       result_ready;
  unit_rsp_t  result;
  logic       mem_req_valid;
  logic       mem_req_ready;
  mem_req_t   mem_req;
  logic       mem_resp_valid;
  mem_resp_t  mem_resp;

  logic [31:0] lcg_state;
  logic [31:0] mem [256];
  logic [31:0] model_mem [256];
  logic [31:0] model_vreg [`MV_NR_VREGS][`MV_NR_ELEMS];
  int          issue_count [16];
  int          done_count [16];
  int          cycle = 0;
  logic [3:0]  next_id;
  logic        hold_results;

  mini_vec dut (
    .clk_i           (clk),
    .rst_i           (rst),
    .issue_valid_i   (issue_valid),
    .issue_ready_o   (issue_ready),
    .issue_req_i     (issue_req),
    .result_valid_o  (result_valid),
    .result_ready_i  (result_ready),
    .result_o        (result),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_o       (mem_req),
    .mem_resp_valid_i(mem_resp_valid),
    .mem_resp_i      (mem_resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Every bit of the word index shows up in the data
  function automatic logic [31:0] fill_word(input logic [7:0] w);
    return {w ^ 8'hc3, w, ~w, 8'h5a};
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < 16; k++) begin
      n += issue_count[k] - done_count[k];
    end
    return n;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic poke(input int word, input logic [31:0] value);
    mem[word]       = value;
    model_mem[word] = value;
  endtask

  task automatic fill_random(input int word);
    for (int e = 0; e < `MV_NR_ELEMS; e++) begin
      poke(word + e, lcg_next());
    end
  endtask

  // Sequential meaning of one instruction, vsub is vs2 minus vs1
  task automatic apply_model(input vec_op_e op, input int vd, input int vs1,
                             input int vs2, input int word);
    logic [31:0] res [`MV_NR_ELEMS];
    for (int e = 0; e < `MV_NR_ELEMS; e++) begin
      case (op)
        OP_VADD: res[e] = model_vreg[vs2][e] + model_vreg[vs1][e];
        OP_VSUB: res[e] = model_vreg[vs2][e] - model_vreg[vs1][e];
        OP_VAND: res[e] = model_vreg[vs2][e] & model_vreg[vs1][e];
        OP_VOR:  res[e] = model_vreg[vs2][e] | model_vreg[vs1][e];
        OP_VXOR: res[e] = model_vreg[vs2][e] ^ model_vreg[vs1][e];
        OP_VLE:  res[e] = model_mem[word + e];
        OP_VSE:  res[e] = model_vreg[vd][e];
        OP_VSLIDEUP: begin
          if (e == 0) res[e] = 32'd0;
          else        res[e] = model_vreg[vs2][e - 1];
        end
        OP_VSLIDEDOWN: begin
          if (e == `MV_NR_ELEMS - 1) res[e] = 32'd0;
          else                       res[e] = model_vreg[vs2][e + 1];
        end
        default: res[e] = 32'd0;
      endcase
    end
    for (int e = 0; e < `MV_NR_ELEMS; e++) begin
      if (op == OP_VSE) model_mem[word + e] = res[e];
      else              model_vreg[vd][e]   = res[e];
    end
  endtask

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic issue(input vec_op_e op, input int vd, input int vs1,
                       input int vs2, input int word);
    logic [3:0] id;
    int         waited;
    waited  = 0;
    id      = next_id;
    next_id = next_id + 4'd1;
    issue_count[id]++;
    apply_model(op, vd, vs1, vs2, word);
    issue_req.op   = op;
    issue_req.vd   = 3'(vd);
    issue_req.vs1  = 3'(vs1);
    issue_req.vs2  = 3'(vs2);
    issue_req.addr = 32'(word * 4);
    issue_req.id   = id;
    issue_valid    = 1'b1;
    #1;
    while (!issue_ready) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run($sformatf("instruction id %0d was never accepted", id));
      end
    end
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run($sformatf("%0d results never came back", pending()));
      end
    end
    // Leave room for a late duplicate to show up
    idle(4);
  endtask

  task automatic check_region(input int word);
    for (int e = 0; e < `MV_NR_ELEMS; e++) begin
      check_value($sformatf("mem[0x%03h]", (word + e) * 4), mem[word + e],
                  model_mem[word + e]);
    end
  endtask

  ////////////////////
  // Memory and results
  ////////////////////

  initial begin : memory_model
    logic [31:0] r;
    int          delay;
    int          due;
    int          last_due;
    logic [31:0] rdata_q [$];
    int          due_q [$];
    result_ready   = 1'b1;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    last_due       = 0;
    for (int k = 0; k < 16; k++) begin
      done_count[k] = 0;
    end
    forever begin
      @(negedge clk);
      r             = lcg_next();
      result_ready  = !hold_results;
      mem_req_ready = (r[17:16] != 2'b00);
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        mem_resp_valid = 1'b1;
        mem_resp.rdata = rdata_q.pop_front();
        due_q.delete(0);
      end else begin
        mem_resp_valid = 1'b0;
      end
      #1;
      // Handshakes that complete at the next rising edge
      if (mem_req_valid && mem_req_ready) begin
        if (mem_req.addr[31:10] != '0 || mem_req.addr[1:0] != 2'b00) begin
          fail_run($sformatf("memory request to address 0x%08h is outside the model",
                             mem_req.addr));
        end
        if (mem_req.write) begin
          mem[mem_req.addr[9:2]] = mem_req.wdata;
        end else begin
          delay = 1 + int'(r[25:24]) % 3;
          due   = cycle + 1 + delay;
          if (due <= last_due) due = last_due + 1;
          last_due = due;
          rdata_q.push_back(mem[mem_req.addr[9:2]]);
          due_q.push_back(due);
        end
      end
      if (result_valid && result_ready) begin
        if (done_count[result.id] >= issue_count[result.id]) begin
          fail_run($sformatf("result for id %0d arrived without an open instruction",
                             result.id));
        end
        done_count[result.id]++;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    #1;
    check_value("result_valid_o", 32'(result_valid), 32'd0);
    check_value("mem_req_valid_o", 32'(mem_req_valid), 32'd0);
    check_value("issue_ready_o", 32'(issue_ready), 32'd1);
    @(negedge clk);
  endtask

  task automatic test_load_store();
    issue(OP_VLE, 1, 1, 1, 0);
    issue(OP_VSE, 1, 1, 1, 16);
    drain();
    for (int e = 0; e < `MV_NR_ELEMS; e++) begin
      check_value($sformatf("mem[0x%03h]", (16 + e) * 4), mem[16 + e], mem[e]);
    end
    check_region(16);
  endtask

  task automatic test_arith();
    int dst [5] = '{4, 5, 6, 7, 1};
    fill_random(32);
    fill_random(36);
    // Carry out of add and borrow out of sub in element 0
    poke(32, 32'hffff_fff0);
    poke(36, 32'h0000_0025);
    issue(OP_VLE, 2, 2, 2, 32);
    issue(OP_VLE, 3, 3, 3, 36);
    issue(OP_VADD, 4, 2, 3, 0);
    issue(OP_VSUB, 5, 2, 3, 0);
    issue(OP_VAND, 6, 2, 3, 0);
    issue(OP_VOR,  7, 2, 3, 0);
    issue(OP_VXOR, 1, 2, 3, 0);
    for (int k = 0; k < 5; k++) begin
      issue(OP_VSE, dst[k], dst[k], dst[k], 48 + 4 * k);
    end
    drain();
    for (int k = 0; k < 5; k++) begin
      check_region(48 + 4 * k);
    end
  endtask

  task automatic test_slides();
    issue(OP_VSLIDEUP, 4, 2, 2, 0);
    issue(OP_VSLIDEDOWN, 5, 3, 3, 0);
    issue(OP_VSE, 4, 4, 4, 72);
    issue(OP_VSE, 5, 5, 5, 76);
    drain();
    check_region(72);
    check_region(76);
    check_value("slide up element 0", mem[72], 32'd0);
    check_value("slide down element 3", mem[79], 32'd0);
  endtask

  // Each instruction reads the previous one's destination
  task automatic test_dep_chain();
    fill_random(80);
    issue(OP_VLE, 1, 1, 1, 80);
    issue(OP_VADD, 2, 1, 3, 0);
    issue(OP_VSLIDEDOWN, 4, 2, 2, 0);
    issue(OP_VXOR, 5, 1, 4, 0);
    issue(OP_VSE, 5, 5, 5, 88);
    drain();
    check_region(88);
  endtask

  task automatic test_result_backpressure();
    hold_results = 1'b1;
    idle(2);
    issue(OP_VADD, 4, 1, 2, 0);
    issue(OP_VXOR, 5, 1, 2, 0);
    issue(OP_VSLIDEUP, 6, 1, 1, 0);
    issue(OP_VLE, 7, 7, 7, 96);
    idle(60);
    check_value("result_valid_o", 32'(result_valid), 32'd1);
    check_value("results pending while held", 32'(pending()), 32'd4);
    hold_results = 1'b0;
    drain();
    for (int k = 0; k < 4; k++) begin
      issue(OP_VSE, 4 + k, 4 + k, 4 + k, 100 + 4 * k);
    end
    drain();
    for (int k = 0; k < 4; k++) begin
      check_region(100 + 4 * k);
    end
  endtask

  initial begin : main
    rst          = 1'b1;
    issue_valid  = 1'b0;
    issue_req    = '0;
    hold_results = 1'b0;
    lcg_state    = 32'd10213;
    next_id      = 4'd0;
    for (int k = 0; k < 16; k++) begin
      issue_count[k] = 0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i]       = fill_word(8'(i));
      model_mem[i] = mem[i];
    end
    for (int r = 0; r < `MV_NR_VREGS; r++) begin
      for (int e = 0; e < `MV_NR_ELEMS; e++) begin
        model_vreg[r][e] = 32'd0;
      end
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_load_store();
    test_arith();
    test_slides();
    test_dep_chain();
    test_result_backpressure();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: mini_vec.f
+incdir+include
verilog/mini_vec_pkg.sv
verilog/mini_vec_vrf.sv
verilog/mini_vec_controller.sv
verilog/mini_vec_vfu.sv
verilog/mini_vec_vlsu.sv
verilog/mini_vec_vsldu.sv
verilog/mini_vec.sv
tests/mini_vec_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mini_vec testbench with Verilator.
# The run fails if the log holds the fail message or a step returns an error.

cd "$(dirname "$0")" || exit 1

LOG=mini_vec_sim.log

verilator --binary --timing --timescale 1ns/100ps -f mini_vec.f \
  --top-module mini_vec_tb -o mini_vec_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mini_vec_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
